// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_ooo_core
RTL_TOP    := ooo_core
FILELIST   := files.f
OBJ_DIR    := obj_dir
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall

SOURCES := $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

run: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== alu_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_unit (
    input  wire logic                        clk,
    input  wire logic                        reset,
    input  wire logic                        issue_valid,
    input  wire ooo_uarch_pkg::alu_payload_t payload,
    input  wire ooo_isa_pkg::word_t          a,
    input  wire ooo_isa_pkg::word_t          b,
    output ooo_uarch_pkg::wb_t               wb
);

    ooo_isa_pkg::word_t op_b;
    ooo_isa_pkg::word_t result;

    assign op_b = payload.use_imm ? payload.imm : b;

    always_comb begin
        case (payload.op)
            ooo_isa_pkg::add:    result = a + op_b;
            ooo_isa_pkg::sub:    result = a - op_b;
            ooo_isa_pkg::and_op: result = a & op_b;
            ooo_isa_pkg::or_op:  result = a | op_b;
            ooo_isa_pkg::xor_op: result = a ^ op_b;
            ooo_isa_pkg::sll:    result = a << op_b[4:0];
            ooo_isa_pkg::srl:    result = a >> op_b[4:0];
            ooo_isa_pkg::slt:    result = ooo_isa_pkg::word_t'($signed(a) < $signed(op_b));
            default:             result = '0;  // multiplies never steered here
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wb.valid <= 1'b0;
        end else begin
            wb.valid <= issue_valid;
        end
        wb.tag   <= payload.dest;
        wb.value <= result;
    end

endmodule

`default_nettype wire

// ==== files.f ====
ooo_isa_pkg.sv
ooo_uarch_pkg.sv
rename_dispatch.sv
phys_regfile.sv
issue_queue.sv
alu_unit.sv
mul_pipe.sv
reorder_buffer.sv
ooo_core.sv
tb_ooo_core.sv

// ==== issue_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_queue #(
    parameter int  depth     = 8,
    parameter type payload_t = ooo_uarch_pkg::alu_payload_t
) (
    input  wire logic                     clk,
    input  wire logic                     reset,
    input  wire logic                     in_valid,
    input  wire ooo_uarch_pkg::phys_tag_t in_src1,
    input  wire ooo_uarch_pkg::phys_tag_t in_src2,
    input  wire logic                     in_rdy1,
    input  wire logic                     in_rdy2,
    input  wire payload_t                 in_payload,
    input  wire ooo_uarch_pkg::wb_t       alu_wb,
    input  wire ooo_uarch_pkg::wb_t       mul_wb,
    output logic                          issue_valid,
    output ooo_uarch_pkg::phys_tag_t      issue_src1,
    output ooo_uarch_pkg::phys_tag_t      issue_src2,
    output payload_t                      issue_payload
);

    localparam int IW = $clog2(depth);
    localparam int CW = $clog2(depth + 1);

    typedef struct packed {
        ooo_uarch_pkg::phys_tag_t src1;
        ooo_uarch_pkg::phys_tag_t src2;
        logic                     rdy1;
        logic                     rdy2;
        payload_t                 payload;
    } entry_t;

    entry_t        slots      [depth];
    entry_t        woken      [depth];
    entry_t        slots_next [depth];
    logic [CW-1:0] count;
    logic [CW-1:0] ins_idx;
    logic [IW-1:0] sel_idx;
    logic          sel_found;

    // lowest index is oldest
    always_comb begin
        sel_found = 1'b0;
        sel_idx   = '0;
        for (int i = 0; i < depth; i++) begin
            if (!sel_found && i < int'(count) && slots[i].rdy1 && slots[i].rdy2) begin
                sel_found = 1'b1;
                sel_idx   = IW'(i);
            end
        end
    end

    assign issue_valid   = sel_found;
    assign issue_src1    = slots[sel_idx].src1;
    assign issue_src2    = slots[sel_idx].src2;
    assign issue_payload = slots[sel_idx].payload;
    assign ins_idx       = count - CW'(sel_found);

    always_comb begin
        for (int i = 0; i < depth; i++) begin
            woken[i]      = slots[i];
            woken[i].rdy1 = slots[i].rdy1 || ooo_uarch_pkg::wb_hit(alu_wb, slots[i].src1)
                            || ooo_uarch_pkg::wb_hit(mul_wb, slots[i].src1);
            woken[i].rdy2 = slots[i].rdy2 || ooo_uarch_pkg::wb_hit(alu_wb, slots[i].src2)
                            || ooo_uarch_pkg::wb_hit(mul_wb, slots[i].src2);
        end
        slots_next = woken;
        if (sel_found) begin
            for (int i = 0; i < depth - 1; i++) begin
                if (i >= int'(sel_idx)) begin
                    slots_next[i] = woken[i + 1];  // close the gap
                end
            end
        end
        if (in_valid && int'(ins_idx) < depth) begin
            slots_next[IW'(ins_idx)] = '{src1: in_src1, src2: in_src2, rdy1: in_rdy1,
                                         rdy2: in_rdy2, payload: in_payload};
        end
    end

    always_ff @(posedge clk) begin
        slots <= slots_next;
        if (reset) begin
            count <= '0;
        end else begin
            count <= count + CW'(in_valid) - CW'(sel_found);
        end
    end

    // sized to the rob, so dispatch credits should prevent this
    a_no_insert_when_full: assert property (@(posedge clk) disable iff (reset)
        in_valid |-> count < CW'(depth));

endmodule

`default_nettype wire

// ==== mul_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

module mul_pipe #(
    parameter int stages = 3
) (
    input  wire logic                        clk,
    input  wire logic                        reset,
    input  wire logic                        issue_valid,
    input  wire ooo_uarch_pkg::mul_payload_t payload,
    input  wire ooo_isa_pkg::word_t          a,
    input  wire ooo_isa_pkg::word_t          b,
    output ooo_uarch_pkg::wb_t               wb
);

    localparam int XLEN = ooo_isa_pkg::XLEN;

    typedef struct packed {
        ooo_uarch_pkg::phys_tag_t tag;
        logic                     hi;  // upper half wanted
        logic [2*XLEN-1:0]        prod;
    } stage_t;

    logic                     signed_op;
    logic signed [XLEN:0]     sa;
    logic signed [XLEN:0]     sb;
    logic signed [2*XLEN+1:0] full;
    logic [stages-1:0]        vld;
    stage_t                   pipe [stages];

    // one extra bit per operand covers both signed and unsigned
    assign signed_op = payload.op != ooo_isa_pkg::mulhu;
    assign sa        = {signed_op && a[XLEN-1], a};
    assign sb        = {signed_op && b[XLEN-1], b};
    assign full      = sa * sb;

    always_ff @(posedge clk) begin
        if (reset) begin
            vld <= '0;
        end else begin
            vld <= {vld[stages-2:0], issue_valid};
        end
        pipe[0] <= '{tag: payload.dest, hi: payload.op != ooo_isa_pkg::mul,
                     prod: full[2*XLEN-1:0]};
        for (int k = 1; k < stages; k++) begin
            pipe[k] <= pipe[k-1];
        end
    end

    assign wb.valid = vld[stages-1];
    assign wb.tag   = pipe[stages-1].tag;
    assign wb.value = pipe[stages-1].hi ? pipe[stages-1].prod[2*XLEN-1:XLEN]
                                        : pipe[stages-1].prod[XLEN-1:0];

endmodule

`default_nettype wire

// ==== ooo_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module ooo_core #(
    parameter int rob_depth  = 8,
    parameter int mul_stages = 3
) (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  dispatch_valid,
    input  wire ooo_isa_pkg::uop_t     dispatch_uop,
    output logic                       commit_valid,
    output ooo_isa_pkg::commit_t       commit_data
);

    ooo_uarch_pkg::wb_t           alu_wb;
    ooo_uarch_pkg::wb_t           mul_wb;
    logic                         alu_in_valid;
    logic                         mul_in_valid;
    ooo_uarch_pkg::phys_tag_t     src1;
    ooo_uarch_pkg::phys_tag_t     src2;
    logic                         rdy1;
    logic                         rdy2;
    logic                         disp_rdy1;
    logic                         disp_rdy2;
    ooo_uarch_pkg::alu_payload_t  alu_payload;
    ooo_uarch_pkg::mul_payload_t  mul_payload;
    ooo_isa_pkg::arch_reg_t       alloc_rd;
    ooo_uarch_pkg::phys_tag_t     alloc_tag;
    ooo_uarch_pkg::phys_tag_t     release_tag;
    logic                         free_valid;
    ooo_uarch_pkg::phys_tag_t     free_tag;
    logic                         alu_issue_valid;
    ooo_uarch_pkg::phys_tag_t     alu_issue_src1;
    ooo_uarch_pkg::phys_tag_t     alu_issue_src2;
    ooo_uarch_pkg::alu_payload_t  alu_issue_payload;
    logic                         mul_issue_valid;
    ooo_uarch_pkg::phys_tag_t     mul_issue_src1;
    ooo_uarch_pkg::phys_tag_t     mul_issue_src2;
    ooo_uarch_pkg::mul_payload_t  mul_issue_payload;
    ooo_isa_pkg::word_t           alu_a;
    ooo_isa_pkg::word_t           alu_b;
    ooo_isa_pkg::word_t           mul_a;
    ooo_isa_pkg::word_t           mul_b;
    ooo_uarch_pkg::phys_tag_t     head_tag;
    logic                         head_ready;
    ooo_isa_pkg::word_t           head_value;

    rename_dispatch u_rename_dispatch (
        .clk(clk), .reset(reset),
        .dispatch_valid(dispatch_valid), .dispatch_uop(dispatch_uop),
        .alu_wb(alu_wb), .mul_wb(mul_wb),
        .src_ready1(disp_rdy1), .src_ready2(disp_rdy2),
        .free_valid(free_valid), .free_tag(free_tag),
        .alu_in_valid(alu_in_valid), .mul_in_valid(mul_in_valid),
        .src1(src1), .src2(src2), .rdy1(rdy1), .rdy2(rdy2),
        .alu_payload(alu_payload), .mul_payload(mul_payload),
        .alloc_rd(alloc_rd), .alloc_tag(alloc_tag), .release_tag(release_tag)
    );

    phys_regfile u_phys_regfile (
        .clk(clk), .reset(reset),
        .alu_wb(alu_wb), .mul_wb(mul_wb),
        .alloc_valid(dispatch_valid), .alloc_tag(alloc_tag),
        .alu_src1(alu_issue_src1), .alu_src2(alu_issue_src2),
        .mul_src1(mul_issue_src1), .mul_src2(mul_issue_src2),
        .head_tag(head_tag), .disp_src1(src1), .disp_src2(src2),
        .alu_val1(alu_a), .alu_val2(alu_b), .mul_val1(mul_a), .mul_val2(mul_b),
        .head_value(head_value), .head_ready(head_ready),
        .disp_rdy1(disp_rdy1), .disp_rdy2(disp_rdy2)
    );

    issue_queue #(.depth(rob_depth), .payload_t(ooo_uarch_pkg::alu_payload_t)) u_alu_queue (
        .clk(clk), .reset(reset),
        .in_valid(alu_in_valid), .in_src1(src1), .in_src2(src2),
        .in_rdy1(rdy1), .in_rdy2(rdy2), .in_payload(alu_payload),
        .alu_wb(alu_wb), .mul_wb(mul_wb),
        .issue_valid(alu_issue_valid), .issue_src1(alu_issue_src1),
        .issue_src2(alu_issue_src2), .issue_payload(alu_issue_payload)
    );

    issue_queue #(.depth(rob_depth), .payload_t(ooo_uarch_pkg::mul_payload_t)) u_mul_queue (
        .clk(clk), .reset(reset),
        .in_valid(mul_in_valid), .in_src1(src1), .in_src2(src2),
        .in_rdy1(rdy1), .in_rdy2(rdy2), .in_payload(mul_payload),
        .alu_wb(alu_wb), .mul_wb(mul_wb),
        .issue_valid(mul_issue_valid), .issue_src1(mul_issue_src1),
        .issue_src2(mul_issue_src2), .issue_payload(mul_issue_payload)
    );

    alu_unit u_alu_unit (
        .clk(clk), .reset(reset), .issue_valid(alu_issue_valid),
        .payload(alu_issue_payload), .a(alu_a), .b(alu_b), .wb(alu_wb)
    );

    mul_pipe #(.stages(mul_stages)) u_mul_pipe (
        .clk(clk), .reset(reset), .issue_valid(mul_issue_valid),
        .payload(mul_issue_payload), .a(mul_a), .b(mul_b), .wb(mul_wb)
    );

    reorder_buffer #(.depth(rob_depth)) u_reorder_buffer (
        .clk(clk), .reset(reset),
        .alloc_valid(dispatch_valid), .alloc_rd(alloc_rd),
        .alloc_tag(alloc_tag), .release_tag(release_tag),
        .head_tag(head_tag), .head_ready(head_ready), .head_value(head_value),
        .commit_valid(commit_valid), .commit_data(commit_data),
        .free_valid(free_valid), .free_tag(free_tag)
    );

endmodule

`default_nettype wire

// ==== ooo_isa_pkg.sv ====
`default_nettype none

package ooo_isa_pkg;

    localparam int XLEN     = 32;
    localparam int NUM_ARCH = 32;

    typedef logic [XLEN-1:0]             word_t;
    typedef logic [$clog2(NUM_ARCH)-1:0] arch_reg_t;

    typedef enum logic [3:0] {
        add,
        sub,
        and_op,
        or_op,
        xor_op,
        sll,
        srl,
        slt,
        mul,
        mulh,
        mulhu
    } op_t;

    typedef struct packed {
        op_t       op;
        arch_reg_t rd;
        arch_reg_t rs1;
        arch_reg_t rs2;
        logic      use_imm;  // imm replaces rs2
        word_t     imm;
    } uop_t;

    typedef struct packed {
        arch_reg_t rd;
        word_t     value;
    } commit_t;

endpackage

`default_nettype wire

// ==== ooo_uarch_pkg.sv ====
`default_nettype none

package ooo_uarch_pkg;

    localparam int NUM_PHYS = 64;

    typedef logic [$clog2(NUM_PHYS)-1:0] phys_tag_t;

    // result broadcast from an execution unit
    typedef struct packed {
        logic               valid;
        phys_tag_t          tag;
        ooo_isa_pkg::word_t value;
    } wb_t;

    typedef struct packed {
        ooo_isa_pkg::op_t   op;
        logic               use_imm;
        ooo_isa_pkg::word_t imm;
        phys_tag_t          dest;
    } alu_payload_t;

    typedef struct packed {
        ooo_isa_pkg::op_t op;
        phys_tag_t        dest;
    } mul_payload_t;

    // true when a broadcast produces this tag
    function automatic logic wb_hit(wb_t wb, phys_tag_t tag);
        return wb.valid && wb.tag == tag;
    endfunction

endpackage

`default_nettype wire

// ==== phys_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module phys_regfile (
    input  wire logic                     clk,
    input  wire logic                     reset,
    input  wire ooo_uarch_pkg::wb_t       alu_wb,
    input  wire ooo_uarch_pkg::wb_t       mul_wb,
    input  wire logic                     alloc_valid,
    input  wire ooo_uarch_pkg::phys_tag_t alloc_tag,
    input  wire ooo_uarch_pkg::phys_tag_t alu_src1,
    input  wire ooo_uarch_pkg::phys_tag_t alu_src2,
    input  wire ooo_uarch_pkg::phys_tag_t mul_src1,
    input  wire ooo_uarch_pkg::phys_tag_t mul_src2,
    input  wire ooo_uarch_pkg::phys_tag_t head_tag,
    input  wire ooo_uarch_pkg::phys_tag_t disp_src1,
    input  wire ooo_uarch_pkg::phys_tag_t disp_src2,
    output ooo_isa_pkg::word_t            alu_val1,
    output ooo_isa_pkg::word_t            alu_val2,
    output ooo_isa_pkg::word_t            mul_val1,
    output ooo_isa_pkg::word_t            mul_val2,
    output ooo_isa_pkg::word_t            head_value,
    output logic                          head_ready,
    output logic                          disp_rdy1,
    output logic                          disp_rdy2
);

    ooo_isa_pkg::word_t                 values [ooo_uarch_pkg::NUM_PHYS];
    logic [ooo_uarch_pkg::NUM_PHYS-1:0] ready;

    assign alu_val1   = values[alu_src1];
    assign alu_val2   = values[alu_src2];
    assign mul_val1   = values[mul_src1];
    assign mul_val2   = values[mul_src2];
    assign head_value = values[head_tag];
    assign head_ready = ready[head_tag];
    assign disp_rdy1  = ready[disp_src1];
    assign disp_rdy2  = ready[disp_src2];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < ooo_uarch_pkg::NUM_PHYS; i++) begin
                values[i] <= '0;
                ready[i]  <= i < ooo_isa_pkg::NUM_ARCH;  // identity map starts ready
            end
        end else begin
            if (alloc_valid) begin
                ready[alloc_tag] <= 1'b0;
            end
            if (alu_wb.valid) begin
                values[alu_wb.tag] <= alu_wb.value;
                ready[alu_wb.tag]  <= 1'b1;
            end
            if (mul_wb.valid) begin
                values[mul_wb.tag] <= mul_wb.value;
                ready[mul_wb.tag]  <= 1'b1;
            end
        end
    end

    // each tag has a single producer in flight
    a_wb_tags_distinct: assert property (@(posedge clk) disable iff (reset)
        alu_wb.valid && mul_wb.valid |-> alu_wb.tag != mul_wb.tag);

endmodule

`default_nettype wire

// ==== rename_dispatch.sv ====
`timescale 1ns/1ps
`default_nettype none

module rename_dispatch (
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire logic                       dispatch_valid,
    input  wire ooo_isa_pkg::uop_t          dispatch_uop,
    input  wire ooo_uarch_pkg::wb_t         alu_wb,
    input  wire ooo_uarch_pkg::wb_t         mul_wb,
    input  wire logic                       src_ready1,
    input  wire logic                       src_ready2,
    input  wire logic                       free_valid,
    input  wire ooo_uarch_pkg::phys_tag_t   free_tag,
    output logic                            alu_in_valid,
    output logic                            mul_in_valid,
    output ooo_uarch_pkg::phys_tag_t        src1,
    output ooo_uarch_pkg::phys_tag_t        src2,
    output logic                            rdy1,
    output logic                            rdy2,
    output ooo_uarch_pkg::alu_payload_t     alu_payload,
    output ooo_uarch_pkg::mul_payload_t     mul_payload,
    output ooo_isa_pkg::arch_reg_t          alloc_rd,
    output ooo_uarch_pkg::phys_tag_t        alloc_tag,
    output ooo_uarch_pkg::phys_tag_t        release_tag
);

    localparam int FREE_DEPTH = ooo_uarch_pkg::NUM_PHYS - ooo_isa_pkg::NUM_ARCH;
    localparam int FW         = $clog2(FREE_DEPTH);

    ooo_uarch_pkg::phys_tag_t map_table [ooo_isa_pkg::NUM_ARCH];
    ooo_uarch_pkg::phys_tag_t free_list [FREE_DEPTH];
    logic [FW-1:0]            fl_head;
    logic [FW-1:0]            fl_tail;
    logic [FW:0]              fl_count;
    logic                     is_mul;
    logic                     writes_rd;

    assign is_mul    = dispatch_uop.op inside {ooo_isa_pkg::mul, ooo_isa_pkg::mulh,
                                               ooo_isa_pkg::mulhu};
    assign writes_rd = dispatch_uop.rd != '0;

    assign src1 = map_table[dispatch_uop.rs1];
    assign src2 = map_table[dispatch_uop.rs2];
    // same-cycle broadcast would be missed by the station otherwise
    assign rdy1 = src_ready1 || ooo_uarch_pkg::wb_hit(alu_wb, src1)
                  || ooo_uarch_pkg::wb_hit(mul_wb, src1);
    assign rdy2 = (dispatch_uop.use_imm && !is_mul) || src_ready2
                  || ooo_uarch_pkg::wb_hit(alu_wb, src2) || ooo_uarch_pkg::wb_hit(mul_wb, src2);

    assign alloc_tag   = free_list[fl_head];
    assign alloc_rd    = dispatch_uop.rd;
    assign release_tag = writes_rd ? map_table[dispatch_uop.rd] : alloc_tag;  // x0 drops its own

    assign alu_in_valid = dispatch_valid && !is_mul;
    assign mul_in_valid = dispatch_valid && is_mul;

    always_comb begin
        alu_payload.op      = dispatch_uop.op;
        alu_payload.use_imm = dispatch_uop.use_imm;
        alu_payload.imm     = dispatch_uop.imm;
        alu_payload.dest    = alloc_tag;
        mul_payload.op      = dispatch_uop.op;
        mul_payload.dest    = alloc_tag;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < ooo_isa_pkg::NUM_ARCH; i++) begin
                map_table[i] <= ooo_uarch_pkg::phys_tag_t'(i);
            end
            for (int i = 0; i < FREE_DEPTH; i++) begin
                free_list[i] <= ooo_uarch_pkg::phys_tag_t'(ooo_isa_pkg::NUM_ARCH + i);
            end
            fl_head  <= '0;
            fl_tail  <= '0;
            fl_count <= (FW+1)'(FREE_DEPTH);
        end else begin
            if (dispatch_valid) begin
                fl_head <= fl_head + 1'b1;
                if (writes_rd) begin
                    map_table[dispatch_uop.rd] <= alloc_tag;
                end
            end
            if (free_valid) begin  // tag returned by commit
                free_list[fl_tail] <= free_tag;
                fl_tail            <= fl_tail + 1'b1;
            end
            fl_count <= fl_count + (FW+1)'(free_valid) - (FW+1)'(dispatch_valid);
        end
    end

    // rob credits must keep enough tags in reserve
    a_free_list_not_empty: assert property (@(posedge clk) disable iff (reset)
        dispatch_valid |-> fl_count != '0);

endmodule

`default_nettype wire

// ==== reorder_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer #(
    parameter int depth = 8
) (
    input  wire logic                     clk,
    input  wire logic                     reset,
    input  wire logic                     alloc_valid,
    input  wire ooo_isa_pkg::arch_reg_t   alloc_rd,
    input  wire ooo_uarch_pkg::phys_tag_t alloc_tag,
    input  wire ooo_uarch_pkg::phys_tag_t release_tag,
    output ooo_uarch_pkg::phys_tag_t      head_tag,
    input  wire logic                     head_ready,
    input  wire ooo_isa_pkg::word_t       head_value,
    output logic                          commit_valid,
    output ooo_isa_pkg::commit_t          commit_data,
    output logic                          free_valid,
    output ooo_uarch_pkg::phys_tag_t      free_tag
);

    localparam int PW = $clog2(depth);
    localparam int CW = $clog2(depth + 1);

    typedef struct packed {
        ooo_isa_pkg::arch_reg_t   rd;
        ooo_uarch_pkg::phys_tag_t tag;
        ooo_uarch_pkg::phys_tag_t rel;  // freed on commit
    } rob_entry_t;

    rob_entry_t    entries [depth];
    logic [PW-1:0] head;
    logic [PW-1:0] tail;
    logic [CW-1:0] count;

    // depth need not be a power of two
    function automatic logic [PW-1:0] bump(logic [PW-1:0] p);
        return (p == PW'(depth - 1)) ? '0 : p + 1'b1;
    endfunction

    assign head_tag     = entries[head].tag;
    assign commit_valid = count != '0 && head_ready;
    assign commit_data  = '{rd: entries[head].rd, value: head_value};
    assign free_valid   = commit_valid;
    assign free_tag     = entries[head].rel;

    always_ff @(posedge clk) begin
        if (alloc_valid) begin
            entries[tail] <= '{rd: alloc_rd, tag: alloc_tag, rel: release_tag};
        end
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (alloc_valid) tail <= bump(tail);
            if (commit_valid) head <= bump(head);
            count <= count + CW'(alloc_valid) - CW'(commit_valid);
        end
    end

    // dispatcher must hold a credit per slot
    a_no_alloc_when_full: assert property (@(posedge clk) disable iff (reset)
        alloc_valid |-> count < CW'(depth));

endmodule

`default_nettype wire

// ==== tb_ooo_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ooo_core;

    localparam int ROB_DEPTH    = 8;
    localparam int MUL_STAGES   = 3;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_RANDOM   = 2000;
    localparam int BURST        = 2 * ROB_DEPTH;
    // 31 register loads, 16 alu forms, 3 multiplies
    localparam int NUM_INSTR    = 31 + 19 + BURST + NUM_RANDOM;
    localparam int TIMEOUT      = NUM_INSTR * (ROB_DEPTH + MUL_STAGES + 4) + RESET_CYCLES;

    logic                 clk;
    logic                 reset;
    logic                 dispatch_valid;
    ooo_isa_pkg::uop_t    dispatch_uop;
    logic                 commit_valid;
    ooo_isa_pkg::commit_t commit_data;

    ooo_isa_pkg::word_t   regs [ooo_isa_pkg::NUM_ARCH];  // architectural model
    ooo_isa_pkg::commit_t expected [$];
    logic [31:0]          rng_state;
    int                   credits;
    int                   min_credits;
    int                   sent;
    int                   commits;
    int                   cycles;

    ooo_core #(.rob_depth(ROB_DEPTH), .mul_stages(MUL_STAGES)) dut0 (
        .clk(clk), .reset(reset),
        .dispatch_valid(dispatch_valid), .dispatch_uop(dispatch_uop),
        .commit_valid(commit_valid), .commit_data(commit_data)
    );

    always #2 clk = ~clk;

    task automatic stop_run();
        $display("Errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    function automatic logic [31:0] next_random();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    function automatic ooo_isa_pkg::word_t model_result(ooo_isa_pkg::uop_t u);
        ooo_isa_pkg::word_t a;
        ooo_isa_pkg::word_t b;
        logic [63:0]        prod;
        logic               is_mul;
        is_mul = u.op inside {ooo_isa_pkg::mul, ooo_isa_pkg::mulh, ooo_isa_pkg::mulhu};
        a      = regs[u.rs1];
        b      = (u.use_imm && !is_mul) ? u.imm : regs[u.rs2];
        case (u.op)
            ooo_isa_pkg::add:    return a + b;
            ooo_isa_pkg::sub:    return a - b;
            ooo_isa_pkg::and_op: return a & b;
            ooo_isa_pkg::or_op:  return a | b;
            ooo_isa_pkg::xor_op: return a ^ b;
            ooo_isa_pkg::sll:    return a << b[4:0];
            ooo_isa_pkg::srl:    return a >> b[4:0];
            ooo_isa_pkg::slt: begin
                if (a[31] != b[31]) begin
                    return {31'b0, a[31]};  // negative one is smaller
                end
                return {31'b0, a < b};
            end
            ooo_isa_pkg::mul:    return a * b;
            ooo_isa_pkg::mulh: begin
                prod = {{32{a[31]}}, a} * {{32{b[31]}}, b};
                return prod[63:32];
            end
            ooo_isa_pkg::mulhu: begin
                prod = {32'b0, a} * {32'b0, b};
                return prod[63:32];
            end
            default:             return '0;
        endcase
    endfunction

    function automatic ooo_isa_pkg::uop_t make_uop(ooo_isa_pkg::op_t op,
            ooo_isa_pkg::arch_reg_t rd, ooo_isa_pkg::arch_reg_t rs1,
            ooo_isa_pkg::arch_reg_t rs2, logic use_imm, ooo_isa_pkg::word_t imm);
        ooo_isa_pkg::uop_t u;
        u.op      = op;
        u.rd      = rd;
        u.rs1     = rs1;
        u.rs2     = rs2;
        u.use_imm = use_imm;
        u.imm     = imm;
        return u;
    endfunction

    // one op with random registers and a nonzero rd
    function automatic ooo_isa_pkg::uop_t directed_uop(ooo_isa_pkg::op_t op, logic use_imm);
        logic [31:0] f;
        logic [31:0] imm;
        f   = next_random();
        imm = next_random();
        return make_uop(op, ooo_isa_pkg::arch_reg_t'(1 + f % 31),
                        f[9:5], f[14:10], use_imm, imm);
    endfunction

    function automatic ooo_isa_pkg::uop_t random_uop();
        logic [31:0]       r;
        logic [31:0]       f;
        ooo_isa_pkg::uop_t u;
        r    = next_random();
        f    = next_random();
        u.op = ooo_isa_pkg::op_t'(4'(r % 11));
        // narrow window of x0..x7 keeps chains long
        u.rd      = f[0] ? {2'b00, f[3:1]} : f[8:4];
        u.rs1     = f[9] ? {2'b00, f[12:10]} : f[17:13];
        u.rs2     = f[18] ? {2'b00, f[21:19]} : f[26:22];
        u.use_imm = f[27] && !(u.op inside {ooo_isa_pkg::mul, ooo_isa_pkg::mulh,
                                             ooo_isa_pkg::mulhu});
        u.imm     = next_random();
        if (f[31:30] == 2'b00) begin
            u.rd = '0;
        end
        return u;
    endfunction

    task automatic send_uop(ooo_isa_pkg::uop_t u);
        ooo_isa_pkg::commit_t exp;
        while (credits == 0) begin
            dispatch_valid = 1'b0;
            @(posedge clk);
            #1;
        end
        exp.rd    = u.rd;
        exp.value = model_result(u);
        expected.push_back(exp);
        if (u.rd != '0) begin
            regs[u.rd] = exp.value;  // x0 stays 0
        end
        credits--;
        sent++;
        if (credits < min_credits) begin
            min_credits = credits;
        end
        dispatch_valid = 1'b1;
        dispatch_uop   = u;
        @(posedge clk);
        #1;
    endtask

    task automatic idle_cycles(int n);
        dispatch_valid = 1'b0;
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic wait_drain();
        dispatch_valid = 1'b0;
        while (credits != ROB_DEPTH) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic check_commit(ooo_isa_pkg::commit_t got, ooo_isa_pkg::commit_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: commit_data = {rd %0d, %h}, expected {rd %0d, %h}",
                     $time, got.rd, got.value, exp.rd, exp.value);
            stop_run();
        end
    endtask

    task automatic check_count(int got, int exp);
        if (got != exp) begin
            $display("** Error at %0t: commit count = %0d, expected %0d", $time, got, exp);
            stop_run();
        end
    endtask

    task automatic check_no_commit(logic got);
        if (got !== 1'b0) begin
            $display("** Error at %0t: commit_valid = %b, expected 0", $time, got);
            stop_run();
        end
    endtask

    always @(negedge clk) begin
        if (sent == 0) begin
            check_no_commit(commit_valid);
        end else if (commit_valid === 1'b1) begin
            commits++;
            if (expected.size() != 0) begin
                check_commit(commit_data, expected.pop_front());
                credits++;  // credit returns with each commit
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT) begin
            $display("timeout after %0d cycles, %0d of %0d instructions committed",
                     cycles, commits, sent);
            stop_run();
        end
    end

    initial begin
        logic [31:0] gap;
        clk            = 1'b0;
        reset          = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_uop   = '0;
        rng_state      = 32'd16;
        credits        = ROB_DEPTH;
        min_credits    = ROB_DEPTH;
        sent           = 0;
        commits        = 0;
        cycles         = 0;
        for (int i = 0; i < ooo_isa_pkg::NUM_ARCH; i++) begin
            regs[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        idle_cycles(5);

        // fill x1..x31 from x0 plus an immediate
        for (int r = 1; r < ooo_isa_pkg::NUM_ARCH; r++) begin
            gap = next_random();
            send_uop(make_uop(ooo_isa_pkg::add, ooo_isa_pkg::arch_reg_t'(r), '0, '0, 1'b1, gap));
        end
        for (int op = int'(ooo_isa_pkg::add); op <= int'(ooo_isa_pkg::slt); op++) begin
            send_uop(directed_uop(ooo_isa_pkg::op_t'(4'(op)), 1'b0));
            send_uop(directed_uop(ooo_isa_pkg::op_t'(4'(op)), 1'b1));
        end
        for (int op = int'(ooo_isa_pkg::mul); op <= int'(ooo_isa_pkg::mulhu); op++) begin
            send_uop(directed_uop(ooo_isa_pkg::op_t'(4'(op)), 1'b0));
        end
        wait_drain();

        // dependent multiply chain fills the rob so dispatch has to wait
        min_credits = ROB_DEPTH;
        for (int i = 0; i < BURST; i++) begin
            send_uop(make_uop(ooo_isa_pkg::op_t'(4'(int'(ooo_isa_pkg::mul) + i % 3)),
                              5'd9, 5'd9, 5'd10, 1'b0, '0));
        end
        if (min_credits != 0) begin
            $display("credits never ran out during the back-to-back burst");
            stop_run();
        end
        wait_drain();

        for (int i = 0; i < NUM_RANDOM; i++) begin
            gap = next_random();
            if (gap[2:0] == 3'd0) begin
                idle_cycles(1);
            end
            send_uop(random_uop());
        end
        wait_drain();
        idle_cycles(10);
        check_count(commits, sent);
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire
